/* hw/atop_config.svh */
`ifndef ATOP_CONFIG_SVH
`define ATOP_CONFIG_SVH

// AXI channel widths.
`define ATOP_ID_W 4
`define ATOP_ADDR_W 16 // Byte address.
`define ATOP_DATA_W 32

// Writes forwarded to the memory that may still owe W data.
`define ATOP_MAX_WRITES 4

// Slave memory size in data words.
`define ATOP_MEM_WORDS 256

`endif

/* hw/atop_filter.sv */
`timescale 1ns/1ps
`include "atop_config.svh"

module atop_filter (
	input  logic               clk_i,
	input  logic               rst_ni,
	// Upstream side.
	input  atop_pkg::aw_chan_t slv_aw_i,
	input  logic               slv_aw_valid_i,
	output logic               slv_aw_ready_o,
	input  atop_pkg::w_chan_t  slv_w_i,
	input  logic               slv_w_valid_i,
	output logic               slv_w_ready_o,
	output atop_pkg::b_chan_t  slv_b_o,
	output logic               slv_b_valid_o,
	input  logic               slv_b_ready_i,
	input  atop_pkg::ar_chan_t slv_ar_i,
	input  logic               slv_ar_valid_i,
	output logic               slv_ar_ready_o,
	output atop_pkg::r_chan_t  slv_r_o,
	output logic               slv_r_valid_o,
	input  logic               slv_r_ready_i,
	// Downstream side.
	output atop_pkg::aw_chan_t mst_aw_o,
	output logic               mst_aw_valid_o,
	input  logic               mst_aw_ready_i,
	output atop_pkg::w_chan_t  mst_w_o,
	output logic               mst_w_valid_o,
	input  logic               mst_w_ready_i,
	input  atop_pkg::b_chan_t  mst_b_i,
	input  logic               mst_b_valid_i,
	output logic               mst_b_ready_o,
	output atop_pkg::ar_chan_t mst_ar_o,
	output logic               mst_ar_valid_o,
	input  logic               mst_ar_ready_i,
	input  atop_pkg::r_chan_t  mst_r_i,
	input  logic               mst_r_valid_i,
	output logic               mst_r_ready_o
);
	import atop_pkg::*;

	localparam int unsigned CNT_W = $clog2(`ATOP_MAX_WRITES + 1);
	localparam logic [CNT_W-1:0] MAX_CNT = CNT_W'(`ATOP_MAX_WRITES);

	logic [CNT_W-1:0] w_cnt_d, w_cnt_q; // Forwarded writes still owing W data.
	w_state_e w_state_d, w_state_q;
	r_state_e r_state_d, r_state_q;
	logic [`ATOP_ID_W-1:0] id_d, id_q;
	logic [7:0] r_beats_d, r_beats_q;
	logic r_busy_d, r_busy_q; // Forwarded R burst is mid-transfer.
	atop_class_e aw_class;

	// One-entry length register toward the read path.
	logic [7:0] cmd_len_q;
	logic cmd_valid_q;
	logic cmd_push, cmd_pop;

	assign aw_class = atop_class_e'(slv_aw_i.atop[5:4]);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write path.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		mst_aw_valid_o = 1'b0;
		slv_aw_ready_o = 1'b0;
		mst_w_valid_o = 1'b0;
		slv_w_ready_o = 1'b0;
		mst_b_ready_o = slv_b_ready_i;
		slv_b_valid_o = mst_b_valid_i;
		slv_b_o = mst_b_i;
		id_d = id_q;
		cmd_push = 1'b0;
		w_state_d = w_state_q;
		unique case (w_state_q)
			W_PASS: begin
				if (w_cnt_q < MAX_CNT) begin
					mst_aw_valid_o = slv_aw_valid_i;
					slv_aw_ready_o = mst_aw_ready_i;
				end
				if (w_cnt_q != '0) begin
					mst_w_valid_o = slv_w_valid_i;
					slv_w_ready_o = mst_w_ready_i;
				end
				if (slv_aw_valid_i && aw_class != ATOP_NONE) begin
					mst_aw_valid_o = 1'b0; // Atomic never reaches the memory.
					slv_aw_ready_o = 1'b1;
					id_d = slv_aw_i.id;
					cmd_push = (aw_class != ATOP_STORE);
					w_state_d = (w_cnt_q != '0) ? W_DRAIN : W_ABSORB;
				end
			end
			W_DRAIN: begin
				if (w_cnt_q != '0) begin
					mst_w_valid_o = slv_w_valid_i;
					slv_w_ready_o = mst_w_ready_i;
				end else begin
					w_state_d = W_ABSORB;
				end
			end
			W_ABSORB: begin
				slv_w_ready_o = 1'b1;
				if (slv_w_valid_i && slv_w_i.last) w_state_d = W_ERR_B;
			end
			W_ERR_B: begin
				mst_b_ready_o = 1'b0; // Memory B waits behind the local one.
				slv_b_valid_o = 1'b1;
				slv_b_o.id = id_q;
				slv_b_o.resp = RESP_SLVERR;
				if (slv_b_ready_i) begin
					w_state_d = (cmd_valid_q && !cmd_pop) ? W_WAIT_R : W_PASS;
				end
			end
			W_WAIT_R: begin
				if (!cmd_valid_q) w_state_d = W_PASS;
			end
			default: w_state_d = W_PASS;
		endcase
	end

	always_comb begin
		w_cnt_d = w_cnt_q;
		if (mst_aw_valid_o && mst_aw_ready_i) w_cnt_d = w_cnt_d + 1'b1;
		if (mst_w_valid_o && mst_w_ready_i && slv_w_i.last) w_cnt_d = w_cnt_d - 1'b1;
	end

	always_comb begin
		mst_aw_o = slv_aw_i;
		mst_aw_o.atop = '0;
	end

	assign mst_w_o = slv_w_i;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read path.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign mst_ar_o = slv_ar_i;
	assign mst_ar_valid_o = slv_ar_valid_i;
	assign slv_ar_ready_o = mst_ar_ready_i;

	always_comb begin
		slv_r_valid_o = mst_r_valid_i;
		mst_r_ready_o = slv_r_ready_i;
		slv_r_o = mst_r_i;
		cmd_pop = 1'b0;
		r_beats_d = r_beats_q;
		r_state_d = r_state_q;
		r_busy_d = r_busy_q;
		unique case (r_state_q)
			R_PASS: begin
				if (mst_r_valid_i && slv_r_ready_i) r_busy_d = !mst_r_i.last;
				// A memory beat already on the bus must not be replaced.
				if (cmd_valid_q && !r_busy_d && !(mst_r_valid_i && !slv_r_ready_i)) begin
					r_beats_d = cmd_len_q;
					r_state_d = R_ERR;
				end
			end
			R_ERR: begin
				mst_r_ready_o = 1'b0;
				slv_r_valid_o = 1'b1;
				slv_r_o.id = id_q;
				slv_r_o.data = '0;
				slv_r_o.resp = RESP_SLVERR;
				slv_r_o.last = (r_beats_q == '0);
				if (slv_r_ready_i) begin
					if (r_beats_q == '0) begin
						cmd_pop = 1'b1;
						r_state_d = R_PASS;
					end else begin
						r_beats_d = r_beats_q - 1'b1;
					end
				end
			end
			default: r_state_d = R_PASS;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Registers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			w_cnt_q <= '0;
			w_state_q <= W_PASS;
			r_state_q <= R_PASS;
			r_beats_q <= '0;
			r_busy_q <= 1'b0;
			cmd_valid_q <= 1'b0;
		end else begin
			w_cnt_q <= w_cnt_d;
			w_state_q <= w_state_d;
			r_state_q <= r_state_d;
			r_beats_q <= r_beats_d;
			r_busy_q <= r_busy_d;
			if (cmd_push) begin
				cmd_valid_q <= 1'b1;
			end else if (cmd_pop) begin
				cmd_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		id_q <= id_d;
		if (cmd_push) cmd_len_q <= slv_aw_i.len;
	end

endmodule

/* hw/atop_filter_top.sv */
`timescale 1ns/1ps

module atop_filter_top (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  atop_pkg::aw_chan_t slv_aw_i,
	input  logic               slv_aw_valid_i,
	output logic               slv_aw_ready_o,
	input  atop_pkg::w_chan_t  slv_w_i,
	input  logic               slv_w_valid_i,
	output logic               slv_w_ready_o,
	output atop_pkg::b_chan_t  slv_b_o,
	output logic               slv_b_valid_o,
	input  logic               slv_b_ready_i,
	input  atop_pkg::ar_chan_t slv_ar_i,
	input  logic               slv_ar_valid_i,
	output logic               slv_ar_ready_o,
	output atop_pkg::r_chan_t  slv_r_o,
	output logic               slv_r_valid_o,
	input  logic               slv_r_ready_i
);
	import atop_pkg::*;

	// Filter to memory link.
	aw_chan_t mem_aw;
	w_chan_t mem_w;
	b_chan_t mem_b;
	ar_chan_t mem_ar;
	r_chan_t mem_r;
	logic mem_aw_valid, mem_aw_ready;
	logic mem_w_valid, mem_w_ready;
	logic mem_b_valid, mem_b_ready;
	logic mem_ar_valid, mem_ar_ready;
	logic mem_r_valid, mem_r_ready;

	atop_filter u_filter (
		.clk_i,
		.rst_ni,
		.slv_aw_i,
		.slv_aw_valid_i,
		.slv_aw_ready_o,
		.slv_w_i,
		.slv_w_valid_i,
		.slv_w_ready_o,
		.slv_b_o,
		.slv_b_valid_o,
		.slv_b_ready_i,
		.slv_ar_i,
		.slv_ar_valid_i,
		.slv_ar_ready_o,
		.slv_r_o,
		.slv_r_valid_o,
		.slv_r_ready_i,
		.mst_aw_o       (mem_aw),
		.mst_aw_valid_o (mem_aw_valid),
		.mst_aw_ready_i (mem_aw_ready),
		.mst_w_o        (mem_w),
		.mst_w_valid_o  (mem_w_valid),
		.mst_w_ready_i  (mem_w_ready),
		.mst_b_i        (mem_b),
		.mst_b_valid_i  (mem_b_valid),
		.mst_b_ready_o  (mem_b_ready),
		.mst_ar_o       (mem_ar),
		.mst_ar_valid_o (mem_ar_valid),
		.mst_ar_ready_i (mem_ar_ready),
		.mst_r_i        (mem_r),
		.mst_r_valid_i  (mem_r_valid),
		.mst_r_ready_o  (mem_r_ready)
	);

	axi_mem_slave u_mem (
		.clk_i,
		.rst_ni,
		.slv_aw_i       (mem_aw),
		.slv_aw_valid_i (mem_aw_valid),
		.slv_aw_ready_o (mem_aw_ready),
		.slv_w_i        (mem_w),
		.slv_w_valid_i  (mem_w_valid),
		.slv_w_ready_o  (mem_w_ready),
		.slv_b_o        (mem_b),
		.slv_b_valid_o  (mem_b_valid),
		.slv_b_ready_i  (mem_b_ready),
		.slv_ar_i       (mem_ar),
		.slv_ar_valid_i (mem_ar_valid),
		.slv_ar_ready_o (mem_ar_ready),
		.slv_r_o        (mem_r),
		.slv_r_valid_o  (mem_r_valid),
		.slv_r_ready_i  (mem_r_ready)
	);

endmodule

/* hw/atop_pkg.sv */
package atop_pkg;

`include "atop_config.svh"

	// AXI write and read response codes.
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_e;

	// ATOP class, taken from atop[5:4].
	typedef enum logic [1:0] {
		ATOP_NONE     = 2'b00,
		ATOP_STORE    = 2'b01,
		ATOP_LOAD     = 2'b10,
		ATOP_SWAP_CMP = 2'b11
	} atop_class_e;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Channel payloads.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		logic [`ATOP_ID_W-1:0]   id;
		logic [`ATOP_ADDR_W-1:0] addr;
		logic [7:0]              len;  // Beats minus one.
		logic [2:0]              size;
		logic [5:0]              atop;
	} aw_chan_t;

	typedef struct packed {
		logic [`ATOP_DATA_W-1:0] data;
		logic                    last;
	} w_chan_t;

	typedef struct packed {
		logic [`ATOP_ID_W-1:0] id;
		resp_e                 resp;
	} b_chan_t;

	typedef struct packed {
		logic [`ATOP_ID_W-1:0]   id;
		logic [`ATOP_ADDR_W-1:0] addr;
		logic [7:0]              len;
		logic [2:0]              size;
	} ar_chan_t;

	typedef struct packed {
		logic [`ATOP_ID_W-1:0]   id;
		logic [`ATOP_DATA_W-1:0] data;
		resp_e                   resp;
		logic                    last;
	} r_chan_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Filter FSM states.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [2:0] {
		W_PASS,   // Normal forwarding.
		W_DRAIN,  // Finish W data of earlier writes.
		W_ABSORB, // Swallow the ATOP's W beats.
		W_ERR_B,
		W_WAIT_R  // Error read burst still pending.
	} w_state_e;

	typedef enum logic {
		R_PASS,
		R_ERR
	} r_state_e;

endpackage

/* hw/axi_mem_slave.sv */
`timescale 1ns/1ps
`include "atop_config.svh"

module axi_mem_slave (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  atop_pkg::aw_chan_t slv_aw_i,
	input  logic               slv_aw_valid_i,
	output logic               slv_aw_ready_o,
	input  atop_pkg::w_chan_t  slv_w_i,
	input  logic               slv_w_valid_i,
	output logic               slv_w_ready_o,
	output atop_pkg::b_chan_t  slv_b_o,
	output logic               slv_b_valid_o,
	input  logic               slv_b_ready_i,
	input  atop_pkg::ar_chan_t slv_ar_i,
	input  logic               slv_ar_valid_i,
	output logic               slv_ar_ready_o,
	output atop_pkg::r_chan_t  slv_r_o,
	output logic               slv_r_valid_o,
	input  logic               slv_r_ready_i
);
	import atop_pkg::*;

	localparam int unsigned IDX_W = $clog2(`ATOP_MEM_WORDS);

	logic [`ATOP_DATA_W-1:0] mem_q [`ATOP_MEM_WORDS];

	// Write engine.
	logic wr_active_q;
	logic b_valid_q;
	logic [IDX_W-1:0] wr_base_q;
	logic [7:0] wr_beat_q;
	logic [`ATOP_ID_W-1:0] wr_id_q;
	logic [IDX_W-1:0] wr_idx;
	logic aw_hs, w_hs;

	// Read engine.
	logic rd_active_q;
	logic [IDX_W-1:0] rd_base_q;
	logic [7:0] rd_beat_q;
	logic [7:0] rd_len_q;
	logic [`ATOP_ID_W-1:0] rd_id_q;
	logic [IDX_W-1:0] rd_idx;
	logic ar_hs, r_hs;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write side.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign slv_aw_ready_o = !wr_active_q && !b_valid_q; // Idle only.
	assign slv_w_ready_o = wr_active_q;
	assign slv_b_valid_o = b_valid_q;
	assign slv_b_o = '{id: wr_id_q, resp: RESP_OKAY};

	assign aw_hs = slv_aw_valid_i && slv_aw_ready_o;
	assign w_hs = slv_w_valid_i && slv_w_ready_o;
	assign wr_idx = wr_base_q + IDX_W'(wr_beat_q);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			wr_active_q <= 1'b0;
			b_valid_q <= 1'b0;
			wr_beat_q <= '0;
		end else begin
			if (aw_hs) begin
				wr_active_q <= 1'b1;
				wr_beat_q <= '0;
			end else if (w_hs) begin
				wr_beat_q <= wr_beat_q + 1'b1;
				if (slv_w_i.last) begin
					wr_active_q <= 1'b0;
					b_valid_q <= 1'b1; // Response on the next cycle.
				end
			end
			if (b_valid_q && slv_b_ready_i) b_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (aw_hs) begin
			wr_base_q <= slv_aw_i.addr[IDX_W+1:2];
			wr_id_q <= slv_aw_i.id;
		end
		if (w_hs) mem_q[wr_idx] <= slv_w_i.data;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Read side.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign slv_ar_ready_o = !rd_active_q;
	assign slv_r_valid_o = rd_active_q;

	assign ar_hs = slv_ar_valid_i && slv_ar_ready_o;
	assign r_hs = slv_r_valid_o && slv_r_ready_i;
	assign rd_idx = rd_base_q + IDX_W'(rd_beat_q);

	always_comb begin
		slv_r_o.id = rd_id_q;
		slv_r_o.data = mem_q[rd_idx];
		slv_r_o.resp = RESP_OKAY;
		slv_r_o.last = (rd_beat_q == rd_len_q);
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			rd_active_q <= 1'b0;
			rd_beat_q <= '0;
		end else if (ar_hs) begin
			rd_active_q <= 1'b1;
			rd_beat_q <= '0;
		end else if (r_hs) begin
			if (slv_r_o.last) begin
				rd_active_q <= 1'b0;
			end else begin
				rd_beat_q <= rd_beat_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (ar_hs) begin
			rd_base_q <= slv_ar_i.addr[IDX_W+1:2];
			rd_len_q <= slv_ar_i.len;
			rd_id_q <= slv_ar_i.id;
		end
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f vlog.f --top-module tb_atop_filter -o sim_atop

./obj_dir/sim_atop +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "Finished with errors" sim.log; then
	echo "Simulation failed."
	exit 1
fi
if ! grep -q "Finished with no errors" sim.log; then
	echo "Simulation ended before its final report."
	exit 1
fi
echo "Simulation passed."

/* verification/atop_filter_checker.sv */
`timescale 1ns/1ps
`include "atop_config.svh"

module atop_filter_checker (
	input logic                                    clk_i,
	input logic                                    rst_ni,
	input atop_pkg::aw_chan_t                      aw_i,
	input logic                                    aw_valid_i,
	input atop_pkg::b_chan_t                       b_i,
	input logic                                    b_valid_i,
	input logic                                    b_ready_i,
	input atop_pkg::r_chan_t                       r_i,
	input logic                                    r_valid_i,
	input logic                                    r_ready_i,
	input atop_pkg::w_state_e                      w_state_i,
	input atop_pkg::r_state_e                      r_state_i,
	input logic [$clog2(`ATOP_MAX_WRITES + 1)-1:0] w_cnt_i
);
	import atop_pkg::*;

	int unsigned fail_cnt = 0;

	// Atomics never reach the memory.
	assert property (@(posedge clk_i) disable iff (!rst_ni)
		aw_valid_i |-> atop_class_e'(aw_i.atop[5:4]) == ATOP_NONE)
		else begin
			fail_cnt++;
			$error("atomic AW forwarded to the memory");
		end

	// Local error B holds its payload under back-pressure.
	assert property (@(posedge clk_i) disable iff (!rst_ni)
		(w_state_i == W_ERR_B && b_valid_i && !b_ready_i) |=> $stable(b_i))
		else begin
			fail_cnt++;
			$error("error B payload changed while stalled");
		end

	assert property (@(posedge clk_i) disable iff (!rst_ni)
		(r_state_i == R_ERR && r_valid_i && !r_ready_i) |=> $stable(r_i))
		else begin
			fail_cnt++;
			$error("error R payload changed while stalled");
		end

	assert property (@(posedge clk_i) disable iff (!rst_ni)
		int'(w_cnt_i) <= `ATOP_MAX_WRITES)
		else begin
			fail_cnt++;
			$error("outstanding write count above its limit");
		end

endmodule

bind atop_filter atop_filter_checker u_checker (
	.clk_i      (clk_i),
	.rst_ni     (rst_ni),
	.aw_i       (slv_aw_i),
	.aw_valid_i (mst_aw_valid_o),
	.b_i        (slv_b_o),
	.b_valid_i  (slv_b_valid_o),
	.b_ready_i  (slv_b_ready_i),
	.r_i        (slv_r_o),
	.r_valid_i  (slv_r_valid_o),
	.r_ready_i  (slv_r_ready_i),
	.w_state_i  (w_state_q),
	.r_state_i  (r_state_q),
	.w_cnt_i    (w_cnt_q)
);

/* verification/tb_atop_filter.sv */
`timescale 1ns/1ps
`include "atop_config.svh"

module tb_atop_filter;
	import atop_pkg::*;

	localparam int unsigned N_WR = 8;
	localparam int unsigned MAX_BEATS = 8;
	localparam int unsigned REGION_BYTES = 64; // Sixteen words per test region.
	localparam int unsigned ADDR_W = `ATOP_ADDR_W;
	localparam int unsigned ID_W = `ATOP_ID_W;
	localparam int unsigned IDX_W = $clog2(`ATOP_MEM_WORDS);
	localparam int unsigned N_OPS = 2 * N_WR + 10;
	localparam int unsigned LIMIT = N_OPS * MAX_BEATS * 20; // Room for ready stalls.

	logic clk = 1'b0;
	logic rst_n;
	aw_chan_t aw;
	logic aw_valid, aw_ready;
	w_chan_t w;
	logic w_valid, w_ready;
	b_chan_t b;
	logic b_valid;
	logic b_ready = 1'b0;
	ar_chan_t ar;
	logic ar_valid, ar_ready;
	r_chan_t r;
	logic r_valid;
	logic r_ready = 1'b0;

	logic [`ATOP_DATA_W-1:0] ref_mem [`ATOP_MEM_WORDS];
	logic [7:0] wr_len [N_WR];
	b_chan_t exp_b_q [$];
	r_chan_t exp_r_q [$];
	int b_errs = 0;
	int r_errs = 0;
	int other_errs = 0;
	int cycles = 0;

	atop_filter_top dut (
		.clk_i          (clk),
		.rst_ni         (rst_n),
		.slv_aw_i       (aw),
		.slv_aw_valid_i (aw_valid),
		.slv_aw_ready_o (aw_ready),
		.slv_w_i        (w),
		.slv_w_valid_i  (w_valid),
		.slv_w_ready_o  (w_ready),
		.slv_b_o        (b),
		.slv_b_valid_o  (b_valid),
		.slv_b_ready_i  (b_ready),
		.slv_ar_i       (ar),
		.slv_ar_valid_i (ar_valid),
		.slv_ar_ready_o (ar_ready),
		.slv_r_o        (r),
		.slv_r_valid_o  (r_valid),
		.slv_r_ready_i  (r_ready)
	);

	always #20 clk = ~clk;

	// Random back-pressure on both response channels.
	always @(negedge clk) begin
		b_ready = ($urandom_range(0, 3) != 0);
		r_ready = ($urandom_range(0, 3) != 0);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic b_chan_t ref_b(input aw_chan_t req);
		b_chan_t resp;
		resp.id = req.id;
		resp.resp = (atop_class_e'(req.atop[5:4]) == ATOP_NONE) ? RESP_OKAY : RESP_SLVERR;
		return resp;
	endfunction

	// Beat n of a read burst, or of the zero-data error burst of an atomic.
	function automatic r_chan_t ref_r(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
			input logic [7:0] len, input int n, input logic err);
		r_chan_t beat;
		logic [IDX_W-1:0] idx;
		idx = addr[IDX_W+1:2] + IDX_W'(n);
		beat.id = id;
		beat.data = err ? '0 : ref_mem[idx];
		beat.resp = err ? RESP_SLVERR : RESP_OKAY;
		beat.last = (n == int'(len));
		return beat;
	endfunction

	task automatic check_b(input b_chan_t got, input b_chan_t exp_b);
		if (got !== exp_b) begin
			b_errs++;
			$display("error slv_b_o: got %h, expected %h", got, exp_b);
		end
	endtask

	task automatic check_r(input r_chan_t got, input r_chan_t exp_r);
		if (got !== exp_r) begin
			r_errs++;
			$display("error slv_r_o: got %h, expected %h", got, exp_r);
		end
	endtask

	// B may overtake an earlier write's response, so it is matched by ID.
	always @(posedge clk) begin
		int k;
		int hit;
		if (rst_n && b_valid && b_ready) begin
			hit = -1;
			for (k = 0; k < exp_b_q.size(); k++) begin
				if (hit < 0 && exp_b_q[k].id == b.id) hit = k;
			end
			if (hit < 0) begin
				other_errs++;
				$display("A write response with ID %h arrived for no outstanding write", b.id);
			end else begin
				check_b(b, exp_b_q[hit]);
				exp_b_q.delete(hit);
			end
		end
		if (rst_n && r_valid && r_ready) begin
			if (exp_r_q.size() == 0) begin
				other_errs++;
				$display("A read beat arrived while no read or atomic was outstanding");
			end else begin
				check_r(r, exp_r_q.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Timeout: the tests did not complete within %0d cycles", LIMIT);
			$display("Finished with errors");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic aw_chan_t make_aw(input logic [ID_W-1:0] id, input int region,
			input logic [5:0] atop);
		aw_chan_t req;
		req.id = id;
		req.addr = ADDR_W'(region * REGION_BYTES);
		req.len = 8'($urandom_range(0, MAX_BEATS - 1));
		req.size = 3'd2;
		req.atop = atop;
		return req;
	endfunction

	task automatic expect_write(input aw_chan_t req);
		atop_class_e cls;
		int n;
		cls = atop_class_e'(req.atop[5:4]);
		exp_b_q.push_back(ref_b(req));
		if (cls == ATOP_LOAD || cls == ATOP_SWAP_CMP) begin
			for (n = 0; n <= int'(req.len); n++) begin
				exp_r_q.push_back(ref_r(req.id, req.addr, req.len, n, 1'b1));
			end
		end
	endtask

	task automatic send_aw(input aw_chan_t req);
		aw = req;
		aw_valid = 1'b1;
		do @(posedge clk); while (!aw_ready);
		@(negedge clk);
		aw_valid = 1'b0;
	endtask

	// Random data beats; only ordinary writes change the reference memory.
	task automatic send_w(input aw_chan_t req);
		w_chan_t beat;
		logic [IDX_W-1:0] idx;
		int n;
		for (n = 0; n <= int'(req.len); n++) begin
			beat.data = $urandom;
			beat.last = (n == int'(req.len));
			idx = req.addr[IDX_W+1:2] + IDX_W'(n);
			if (req.atop == '0) ref_mem[idx] = beat.data;
			w = beat;
			w_valid = 1'b1;
			do @(posedge clk); while (!w_ready);
			@(negedge clk);
			w_valid = 1'b0;
		end
	endtask

	task automatic wait_idle();
		while (exp_b_q.size() != 0 || exp_r_q.size() != 0) @(negedge clk);
		repeat (4) @(negedge clk); // Stray beats would show up here.
	endtask

	task automatic do_write(input aw_chan_t req);
		expect_write(req);
		send_aw(req);
		send_w(req);
		wait_idle();
	endtask

	task automatic do_read(input int region, input logic [7:0] len);
		ar_chan_t req;
		int n;
		req.id = ID_W'(region);
		req.addr = ADDR_W'(region * REGION_BYTES);
		req.len = len;
		req.size = 3'd2;
		for (n = 0; n <= int'(len); n++) begin
			exp_r_q.push_back(ref_r(req.id, req.addr, len, n, 1'b0));
		end
		ar = req;
		ar_valid = 1'b1;
		do @(posedge clk); while (!ar_ready);
		@(negedge clk);
		ar_valid = 1'b0;
		wait_idle();
	endtask

	initial begin
		aw_chan_t req;
		aw_chan_t atop_req;
		int i;
		int unsigned asrt_errs;
		void'($urandom(62835));
		rst_n = 1'b0;
		aw = '0;
		aw_valid = 1'b0;
		w = '0;
		w_valid = 1'b0;
		ar = '0;
		ar_valid = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// Ordinary bursts, then read every region back.
		for (i = 0; i < N_WR; i++) begin
			req = make_aw(ID_W'(i), i, 6'h00);
			wr_len[i] = req.len;
			do_write(req);
		end
		for (i = 0; i < N_WR; i++) begin
			do_read(i, wr_len[i]);
		end

		do_write(make_aw(4'hc, 0, 6'h10)); // Atomic store.
		do_read(0, wr_len[0]);

		do_write(make_aw(4'hd, 2, 6'h21)); // Atomic load.
		do_write(make_aw(4'he, 3, 6'h30)); // Atomic swap.
		do_read(2, wr_len[2]);
		do_read(3, wr_len[3]);

		// Atomic arrives while an ordinary write still owes its data.
		req = make_aw(4'ha, 10, 6'h00);
		atop_req = make_aw(4'hb, 1, 6'h20);
		expect_write(req);
		expect_write(atop_req);
		send_aw(req);
		send_aw(atop_req);
		send_w(req);
		send_w(atop_req);
		wait_idle();
		do_read(10, req.len);
		do_read(1, wr_len[1]);

		asrt_errs = dut.u_filter.u_checker.fail_cnt;
		$display("B errors: %0d, R errors: %0d, other errors: %0d, assertion failures: %0d",
			b_errs, r_errs, other_errs, asrt_errs);
		if (b_errs + r_errs + other_errs + int'(asrt_errs) == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* vlog.f */
+incdir+hw
hw/atop_pkg.sv
hw/atop_filter.sv
hw/axi_mem_slave.sv
hw/atop_filter_top.sv
verification/atop_filter_checker.sv
verification/tb_atop_filter.sv
